// ==== exec_stage.f ====
rtl/exec_pkg.sv
rtl/opcode_decoder.sv
rtl/cond_eval.sv
rtl/arith_unit.sv
rtl/bitfield_unit.sv
rtl/exec_ctrl.sv
rtl/exec_stage.sv
verification/clk_gen.sv
verification/exec_stage_tb.sv

// ==== rtl/arith_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module arith_unit (
    input  wire exec_pkg::alu_op_t              alu_op,
    input  wire logic [exec_pkg::gpr_width-1:0] val_a,
    input  wire logic [exec_pkg::gpr_width-1:0] val_b,
    input  wire logic [1:0]                     hw,
    input  wire logic [15:0]                    imm16,
    input  wire logic                           o2,
    input  wire logic                           cond_true,
    input  wire logic                           set_flags,
    input  wire logic [3:0]                     flags,
    output logic [exec_pkg::gpr_width-1:0]      alu_res,
    output logic [3:0]                          alu_nzcv
);

    localparam int w = exec_pkg::gpr_width;

    exec_pkg::alu_op_t op_eff;
    logic              subtract;
    logic [w-1:0]      b_in;
    logic [w:0]        sum;       // extra bit is the carry out
    logic [5:0]        lane_shift;

    // o2 picks the second member of each select pair
    always_comb begin
        op_eff = alu_op;
        if (o2 && alu_op == exec_pkg::alu_csel) begin
            op_eff = exec_pkg::alu_csinc;
        end
        if (o2 && alu_op == exec_pkg::alu_csinv) begin
            op_eff = exec_pkg::alu_csneg;
        end
    end

    // one adder with minus as a + ~b + 1
    assign subtract   = (alu_op == exec_pkg::alu_minus);
    assign b_in       = subtract ? ~val_b : val_b;
    assign sum        = {1'b0, val_a} + {1'b0, b_in} + {{w{1'b0}}, subtract};
    assign lane_shift = {hw, 4'b0000};

    always_comb begin
        case (op_eff)
            exec_pkg::alu_plus,
            exec_pkg::alu_minus:  alu_res = sum[w-1:0];
            exec_pkg::alu_or:     alu_res = val_a | val_b;
            exec_pkg::alu_eor:    alu_res = val_a ^ val_b;
            exec_pkg::alu_and:    alu_res = val_a & val_b;
            exec_pkg::alu_not_b:  alu_res = ~val_b;
            exec_pkg::alu_movk: begin
                alu_res = (val_a & ~({{(w-16){1'b0}}, 16'hffff} << lane_shift))
                        | ({{(w-16){1'b0}}, imm16} << lane_shift);
            end
            exec_pkg::alu_csel:   alu_res = cond_true ? val_a : val_b;
            exec_pkg::alu_csinc:  alu_res = cond_true ? val_a : val_b + 1'b1;
            exec_pkg::alu_csinv:  alu_res = cond_true ? val_a : ~val_b;
            exec_pkg::alu_csneg:  alu_res = cond_true ? val_a : ~val_b + 1'b1;
            exec_pkg::alu_pass_a: alu_res = val_a;
            default:              alu_res = '0;
        endcase
    end

    always_comb begin
        alu_nzcv = flags;   // untouched unless the op sets flags
        if (set_flags) begin
            alu_nzcv[exec_pkg::flag_n] = alu_res[w-1];
            alu_nzcv[exec_pkg::flag_z] = (alu_res == '0);
            alu_nzcv[exec_pkg::flag_c] = 1'b0;
            alu_nzcv[exec_pkg::flag_v] = 1'b0;
            if (alu_op == exec_pkg::alu_plus || alu_op == exec_pkg::alu_minus) begin
                // for minus the carry means no borrow
                alu_nzcv[exec_pkg::flag_c] = sum[w];
                alu_nzcv[exec_pkg::flag_v] = (val_a[w-1] == b_in[w-1])
                                           && (sum[w-1] != val_a[w-1]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bitfield_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module bitfield_unit (
    input  wire logic [exec_pkg::gpr_width-1:0] val_a,
    input  wire logic [5:0]                     immr,
    input  wire logic [5:0]                     imms,
    input  wire logic                           signed_field,
    output logic [exec_pkg::gpr_width-1:0]      bf_res
);

    localparam int w = exec_pkg::gpr_width;

    logic [5:0]   top;       // result bit holding the field msb
    logic [w-1:0] field;
    logic [w-1:0] ext_mask;

    // n low ones, n = 64 gives all ones
    function automatic logic [w-1:0] low_mask(input logic [6:0] n);
        return ~({w{1'b1}} << n);
    endfunction

    always_comb begin
        top = imms - immr;   // wraps to 64 - immr + imms on the insert side
        if (imms >= immr) begin
            field = (val_a >> immr) & low_mask({1'b0, top} + 7'd1);
        end else begin
            field = (val_a & low_mask({1'b0, imms} + 7'd1)) << (7'd64 - {1'b0, immr});
        end
        ext_mask = ~low_mask({1'b0, top} + 7'd1);
        if (signed_field && field[top]) begin
            bf_res = field | ext_mask;   // sign fill above the field
        end else begin
            bf_res = field;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cond_eval.sv ====
`timescale 1ns/10ps
`default_nettype none

module cond_eval (
    input  wire exec_pkg::cond_t cond,
    input  wire logic [3:0]      flags,
    output logic                 cond_true
);

    logic n, z, c, v;

    assign n = flags[exec_pkg::flag_n];
    assign z = flags[exec_pkg::flag_z];
    assign c = flags[exec_pkg::flag_c];
    assign v = flags[exec_pkg::flag_v];

    always_comb begin
        case (cond)
            exec_pkg::cond_eq: cond_true = z;
            exec_pkg::cond_ne: cond_true = ~z;
            exec_pkg::cond_cs: cond_true = c;
            exec_pkg::cond_cc: cond_true = ~c;
            exec_pkg::cond_mi: cond_true = n;
            exec_pkg::cond_pl: cond_true = ~n;
            exec_pkg::cond_vs: cond_true = v;
            exec_pkg::cond_vc: cond_true = ~v;
            exec_pkg::cond_hi: cond_true = c & ~z;          // unsigned higher
            exec_pkg::cond_ls: cond_true = ~(c & ~z);
            exec_pkg::cond_ge: cond_true = (n == v);
            exec_pkg::cond_lt: cond_true = (n != v);
            exec_pkg::cond_gt: cond_true = (n == v) & ~z;
            exec_pkg::cond_le: cond_true = ~((n == v) & ~z);
            default:           cond_true = 1'b1;           // al, nv
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_ctrl (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic                             in_valid,
    output logic                                  in_ready,
    input  wire exec_pkg::opcode_t                opcode,
    input  wire logic [exec_pkg::instr_width-1:0] instr,
    input  wire logic [exec_pkg::gpr_width-1:0]   val_a,
    input  wire logic [exec_pkg::gpr_width-1:0]   alu_res,
    input  wire logic [3:0]                       alu_nzcv,
    input  wire logic [exec_pkg::gpr_width-1:0]   bf_res,
    input  wire logic                             cond_true,
    input  wire logic                             out_ready,
    output exec_pkg::alu_op_t                     alu_op,
    output logic                                  set_flags,
    output logic                                  signed_field,
    output exec_pkg::cond_t                       cond_sel,
    output logic [3:0]                            flags,
    output logic                                  out_valid,
    output logic [exec_pkg::gpr_width-1:0]        res,
    output logic [3:0]                            nzcv,
    output logic                                  branch_taken,
    output logic                                  illegal
);

    exec_pkg::stage_state_t state;
    logic                   accept;
    logic                   use_bf;
    logic                   taken_next;

    always_comb begin
        case (opcode)
            exec_pkg::op_ldur, exec_pkg::op_ldp, exec_pkg::op_stur, exec_pkg::op_stp,
            exec_pkg::op_adr, exec_pkg::op_adrp,
            exec_pkg::op_add, exec_pkg::op_adds:      alu_op = exec_pkg::alu_plus;
            exec_pkg::op_sub, exec_pkg::op_subs:      alu_op = exec_pkg::alu_minus;
            exec_pkg::op_orr:                         alu_op = exec_pkg::alu_or;
            exec_pkg::op_eor:                         alu_op = exec_pkg::alu_eor;
            exec_pkg::op_and, exec_pkg::op_ands:      alu_op = exec_pkg::alu_and;
            exec_pkg::op_mvn:                         alu_op = exec_pkg::alu_not_b;
            exec_pkg::op_movk:                        alu_op = exec_pkg::alu_movk;
            exec_pkg::op_csinc_grp:                   alu_op = exec_pkg::alu_csel;
            exec_pkg::op_csinv_grp:                   alu_op = exec_pkg::alu_csinv;
            // target or tested register passed on
            exec_pkg::op_b, exec_pkg::op_bl, exec_pkg::op_b_cond,
            exec_pkg::op_br, exec_pkg::op_blr, exec_pkg::op_ret,
            exec_pkg::op_cbz, exec_pkg::op_cbnz:      alu_op = exec_pkg::alu_pass_a;
            default:                                  alu_op = exec_pkg::alu_zero;
        endcase
    end

    assign set_flags    = (opcode == exec_pkg::op_adds) || (opcode == exec_pkg::op_subs)
                       || (opcode == exec_pkg::op_ands);
    assign signed_field = (opcode == exec_pkg::op_sbfm);
    assign use_bf       = (opcode == exec_pkg::op_ubfm) || (opcode == exec_pkg::op_sbfm);
    assign cond_sel     = (opcode == exec_pkg::op_b_cond) ? exec_pkg::cond_t'(instr[3:0])
                                                          : exec_pkg::cond_t'(instr[15:12]);

    always_comb begin
        case (opcode)
            exec_pkg::op_b, exec_pkg::op_bl, exec_pkg::op_br,
            exec_pkg::op_blr, exec_pkg::op_ret: taken_next = 1'b1;
            exec_pkg::op_b_cond:                taken_next = cond_true;
            exec_pkg::op_cbz:                   taken_next = (val_a == '0);
            exec_pkg::op_cbnz:                  taken_next = (val_a != '0);
            default:                            taken_next = 1'b0;
        endcase
    end

    // single slot that refills in the cycle it drains
    assign in_ready  = (state == exec_pkg::st_empty) || out_ready;
    assign accept    = in_valid && in_ready;
    assign out_valid = (state == exec_pkg::st_full);
    assign nzcv      = flags;   // moves only on accept and so tracks the held item

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= exec_pkg::st_empty;
            flags <= 4'b0000;
        end else begin
            if (accept) begin
                state <= exec_pkg::st_full;
                if (set_flags) begin
                    flags <= alu_nzcv;
                end
            end else if (out_ready) begin
                state <= exec_pkg::st_empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res          <= use_bf ? bf_res : alu_res;
            branch_taken <= taken_next;
            illegal      <= (opcode == exec_pkg::op_hlt) || (opcode == exec_pkg::op_err);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int gpr_width   = 64;
    localparam int instr_width = 32;

    // bit positions inside any 4-bit nzcv vector
    localparam int flag_n = 3;
    localparam int flag_z = 2;
    localparam int flag_c = 1;
    localparam int flag_v = 0;

    // decoded instruction classes
    typedef enum logic [5:0] {
        op_ldur,
        op_ldp,
        op_stur,
        op_stp,
        op_movk,
        op_adr,
        op_adrp,
        op_csinc_grp,   // csel, csinc, cset, cinc
        op_csinv_grp,   // csinv, csneg, csetm
        op_add,
        op_adds,
        op_sub,
        op_subs,        // cmp
        op_mvn,
        op_orr,
        op_eor,
        op_and,
        op_ands,        // tst
        op_ubfm,        // lsl, lsr
        op_sbfm,        // asr
        op_b,
        op_br,
        op_b_cond,
        op_bl,
        op_blr,
        op_cbnz,
        op_cbz,
        op_ret,
        op_nop,
        op_hlt,
        op_err
    } opcode_t;

    typedef enum logic [3:0] {
        alu_plus,
        alu_minus,
        alu_or,
        alu_eor,
        alu_and,
        alu_not_b,
        alu_movk,
        alu_csel,
        alu_csinc,
        alu_csinv,
        alu_csneg,
        alu_pass_a,
        alu_zero
    } alu_op_t;

    // architectural condition encoding
    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc,
        cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt,
        cond_gt, cond_le, cond_al, cond_nv
    } cond_t;

    typedef enum logic {
        st_empty,
        st_full
    } stage_state_t;

endpackage

`default_nettype wire

// ==== rtl/exec_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    // from issue
    input  wire logic                             in_valid,
    output logic                                  in_ready,
    input  wire logic [exec_pkg::instr_width-1:0] instr,
    input  wire logic [exec_pkg::gpr_width-1:0]   val_a,
    input  wire logic [exec_pkg::gpr_width-1:0]   val_b,
    // to next stage
    output logic                                  out_valid,
    input  wire logic                             out_ready,
    output logic [exec_pkg::gpr_width-1:0]        res,
    output logic [3:0]                            nzcv,
    output logic                                  branch_taken,
    output logic                                  illegal
);

    exec_pkg::opcode_t                 opcode;
    exec_pkg::alu_op_t                 alu_op;
    exec_pkg::cond_t                   cond_sel;
    logic                              set_flags;
    logic                              signed_field;
    logic                              cond_true;
    logic [3:0]                        flags;
    logic [3:0]                        alu_nzcv;
    logic [exec_pkg::gpr_width-1:0]    alu_res;
    logic [exec_pkg::gpr_width-1:0]    bf_res;

    opcode_decoder opcode_decoder_i (
        .opcode_bits (instr[31:21]),
        .opcode      (opcode)
    );

    cond_eval cond_eval_i (
        .cond      (cond_sel),
        .flags     (flags),
        .cond_true (cond_true)
    );

    arith_unit arith_unit_i (
        .alu_op    (alu_op),
        .val_a     (val_a),
        .val_b     (val_b),
        .hw        (instr[22:21]),
        .imm16     (instr[20:5]),
        .o2        (instr[10]),
        .cond_true (cond_true),
        .set_flags (set_flags),
        .flags     (flags),
        .alu_res   (alu_res),
        .alu_nzcv  (alu_nzcv)
    );

    bitfield_unit bitfield_unit_i (
        .val_a        (val_a),
        .immr         (instr[21:16]),
        .imms         (instr[15:10]),
        .signed_field (signed_field),
        .bf_res       (bf_res)
    );

    exec_ctrl exec_ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .opcode       (opcode),
        .instr        (instr),
        .val_a        (val_a),
        .alu_res      (alu_res),
        .alu_nzcv     (alu_nzcv),
        .bf_res       (bf_res),
        .cond_true    (cond_true),
        .out_ready    (out_ready),
        .alu_op       (alu_op),
        .set_flags    (set_flags),
        .signed_field (signed_field),
        .cond_sel     (cond_sel),
        .flags        (flags),
        .out_valid    (out_valid),
        .res          (res),
        .nzcv         (nzcv),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

// ==== rtl/opcode_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder (
    input  wire logic [10:0]      opcode_bits,   // instr[31:21]
    output exec_pkg::opcode_t     opcode
);

    always_comb begin
        casez (opcode_bits)
            11'b11111000010: opcode = exec_pkg::op_ldur;
            11'b1010100011?: opcode = exec_pkg::op_ldp;
            11'b11111000000: opcode = exec_pkg::op_stur;
            11'b1010100100?: opcode = exec_pkg::op_stp;
            11'b111100101??: opcode = exec_pkg::op_movk;
            11'b0??10000???: opcode = exec_pkg::op_adr;
            11'b1??10000???: opcode = exec_pkg::op_adrp;
            // select family, o2 and cond sorted out later
            11'b10011010100: opcode = exec_pkg::op_csinc_grp;
            11'b11011010100: opcode = exec_pkg::op_csinv_grp;
            11'b1001000100?: opcode = exec_pkg::op_add;
            11'b10101011000: opcode = exec_pkg::op_adds;
            11'b1101000100?: opcode = exec_pkg::op_sub;
            11'b11101011000: opcode = exec_pkg::op_subs;
            11'b10101010001: opcode = exec_pkg::op_mvn;
            11'b10101010000: opcode = exec_pkg::op_orr;
            11'b11001010000: opcode = exec_pkg::op_eor;
            11'b1001001000?: opcode = exec_pkg::op_and;
            11'b11101010000: opcode = exec_pkg::op_ands;
            11'b110100110??: opcode = exec_pkg::op_ubfm;
            11'b100100111??: opcode = exec_pkg::op_sbfm;
            11'b1001001101?: opcode = exec_pkg::op_sbfm;   // asr alias
            // branches
            11'b000101?????: opcode = exec_pkg::op_b;
            11'b11010110000: opcode = exec_pkg::op_br;
            11'b01010100???: opcode = exec_pkg::op_b_cond;
            11'b100101?????: opcode = exec_pkg::op_bl;
            11'b11010110001: opcode = exec_pkg::op_blr;
            11'b10110101???: opcode = exec_pkg::op_cbnz;
            11'b10110100???: opcode = exec_pkg::op_cbz;
            11'b11010110010: opcode = exec_pkg::op_ret;
            11'b11010101000: opcode = exec_pkg::op_nop;
            11'b11010100010: opcode = exec_pkg::op_hlt;
            default:         opcode = exec_pkg::op_err;   // unknown encoding
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the exec_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f exec_stage.f --top-module exec_stage_tb \
    -o exec_stage_sim || exit 1
out=$(./obj_dir/exec_stage_sim)
echo "$out"
echo "$out" | grep -q "^Verification passed$" && exit 0 || exit 1

// ==== verification/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;   // release after 5 cycles
    end

    always #5 clk = ~clk;   // 10 ns period

endmodule

`default_nettype wire

// ==== verification/exec_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_stage_tb;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] instr;
    logic [63:0] val_a;
    logic [63:0] val_b;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] res;
    logic [3:0]  nzcv;
    logic        branch_taken;
    logic        illegal;

    integer      seed;
    int          checks;
    int          errors;
    int          tests;
    logic        timed_out;
    logic [3:0]  model_flags;
    logic [69:0] exp_q[$];     // {taken, illegal, nzcv, res}
    logic        stalled;
    logic [69:0] held;
    logic [10:0] op_fix[31];
    logic [10:0] op_wild[31];

    clk_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    exec_stage dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .val_a        (val_a),
        .val_b        (val_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .res          (res),
        .nzcv         (nzcv),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    function automatic int rnd_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // cond[3:1] picks the base test and cond[0] inverts it except for nv
    function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
        logic n, z, c, v, r;
        n = f[exec_pkg::flag_n];
        z = f[exec_pkg::flag_z];
        c = f[exec_pkg::flag_c];
        v = f[exec_pkg::flag_v];
        case (cond[3:1])
            3'd0:    r = z;
            3'd1:    r = c;
            3'd2:    r = n;
            3'd3:    r = v;
            3'd4:    r = c & ~z;
            3'd5:    r = (n == v);
            3'd6:    r = (n == v) & ~z;
            default: r = 1'b1;
        endcase
        if (cond[0] && cond != 4'hf) begin
            r = ~r;
        end
        return r;
    endfunction

    function automatic logic [63:0] bitfield(input logic [63:0] a, input int immr,
                                             input int imms, input logic sgn);
        logic [63:0] r;
        int          top;
        int          pos;
        r = '0;
        if (imms >= immr) begin
            for (int i = 0; i <= imms - immr; i++) r[i] = a[immr + i];
            top = imms - immr;
        end else begin
            pos = 64 - immr;
            for (int i = 0; i <= imms; i++) r[pos + i] = a[i];
            top = pos + imms;
        end
        if (sgn && r[top]) begin
            for (int i = top + 1; i < 64; i++) r[i] = 1'b1;
        end
        return r;
    endfunction

    // lowest matching row of the encoding table wins
    // rows follow opcode_t order, row 20 is the asr form of sbfm
    function automatic exec_pkg::opcode_t decode(input logic [10:0] ob);
        exec_pkg::opcode_t op;
        op = exec_pkg::op_err;
        for (int i = 30; i >= 0; i--) begin
            if ((ob & ~op_wild[i]) == op_fix[i]) begin
                op = (i < 20) ? exec_pkg::opcode_t'(i) : exec_pkg::opcode_t'(i - 1);
            end
        end
        return op;
    endfunction

    function automatic logic [69:0] model_exec(input logic [31:0] ins, input logic [63:0] a,
                                               input logic [63:0] b, input logic [3:0] f);
        logic [63:0] r;
        logic [64:0] sum;
        logic [3:0]  nf;
        logic        tk;
        logic        il;
        nf = f;
        r  = '0;
        tk = 1'b0;
        il = 1'b0;
        case (decode(ins[31:21]))
            exec_pkg::op_ldur, exec_pkg::op_ldp, exec_pkg::op_stur, exec_pkg::op_stp,
            exec_pkg::op_adr, exec_pkg::op_adrp, exec_pkg::op_add: r = a + b;
            exec_pkg::op_adds: begin
                sum = {1'b0, a} + {1'b0, b};
                r   = sum[63:0];
                nf  = {r[63], r == 64'd0, sum[64], (a[63] == b[63]) && (r[63] != a[63])};
            end
            exec_pkg::op_sub:  r = a - b;
            exec_pkg::op_subs: begin
                r  = a - b;
                nf = {r[63], r == 64'd0, a >= b, (a[63] != b[63]) && (r[63] != a[63])};
            end
            exec_pkg::op_mvn:  r = ~b;
            exec_pkg::op_orr:  r = a | b;
            exec_pkg::op_eor:  r = a ^ b;
            exec_pkg::op_and:  r = a & b;
            exec_pkg::op_ands: begin
                r  = a & b;
                nf = {r[63], r == 64'd0, 2'b00};
            end
            exec_pkg::op_movk: begin
                r = a;
                r[ins[22:21] * 16 +: 16] = ins[20:5];
            end
            exec_pkg::op_csinc_grp: begin
                r = cond_holds(ins[15:12], f) ? a : (ins[10] ? b + 64'd1 : b);
            end
            exec_pkg::op_csinv_grp: begin
                r = cond_holds(ins[15:12], f) ? a : (ins[10] ? 64'd0 - b : ~b);
            end
            exec_pkg::op_ubfm: r = bitfield(a, int'(ins[21:16]), int'(ins[15:10]), 1'b0);
            exec_pkg::op_sbfm: r = bitfield(a, int'(ins[21:16]), int'(ins[15:10]), 1'b1);
            exec_pkg::op_b, exec_pkg::op_bl, exec_pkg::op_br,
            exec_pkg::op_blr, exec_pkg::op_ret: begin
                r  = a;
                tk = 1'b1;
            end
            exec_pkg::op_b_cond: begin
                r  = a;
                tk = cond_holds(ins[3:0], f);
            end
            exec_pkg::op_cbz: begin
                r  = a;
                tk = (a == 64'd0);
            end
            exec_pkg::op_cbnz: begin
                r  = a;
                tk = (a != 64'd0);
            end
            exec_pkg::op_hlt, exec_pkg::op_err: il = 1'b1;
            default: r = '0;   // nop
        endcase
        return {tk, il, nf, r};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // class 31 is a fully random opcode field
    task automatic build_instr(input int cls, output logic [31:0] ins);
        logic [10:0] ob;
        ob = 11'($random(seed));
        if (cls < 31) begin
            ob = op_fix[cls] | (ob & op_wild[cls]);
        end
        ins = {ob, 21'($random(seed))};
    endtask

    task automatic send(input logic [31:0] ins, input logic [63:0] a, input logic [63:0] b);
        int cnt;
        cnt = 0;
        in_valid <= 1'b1;
        instr    <= ins;
        val_a    <= a;
        val_b    <= b;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > 1000) begin
                $display("timeout: input was never accepted");
                timed_out = 1'b1;
            end
        end while (!in_ready && !timed_out);
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int          e0;
        int          cls;
        int          cnt;
        logic [31:0] ins;
        logic [63:0] a;
        logic [63:0] b;
        int          arith_set[15] = '{0, 1, 2, 3, 5, 6, 9, 10, 11, 12, 13, 14, 15, 16, 17};
        int          sel_set[7]    = '{7, 8, 7, 8, 10, 12, 17};
        int          br_set[13]    = '{21, 22, 23, 24, 25, 26, 27, 28, 29, 30, 31, 10, 12};
        e0 = errors;
        for (int i = 0; i < count && !timed_out; i++) begin
            case (kind)
                0:       cls = 7 + rnd_below(2);
                1:       cls = arith_set[rnd_below(15)];
                2:       cls = sel_set[rnd_below(7)];
                3:       cls = 4 + ((rnd_below(4) == 0) ? 0 : 14 + rnd_below(3));
                4:       cls = br_set[rnd_below(13)];
                default: cls = rnd_below(32);
            endcase
            build_instr(cls, ins);
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            if (rnd_below(4) == 0) a = '0;          // zero tests for cbz and z flag
            if (rnd_below(4) == 0) b = a;
            send(ins, a, b);
        end
        in_valid <= 1'b0;
        cnt = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            cnt++;
            if (cnt > 1000) begin
                $display("timeout: outputs did not drain after test %s", name);
                timed_out = 1'b1;
            end
        end
        tests++;
        $display("test %s done, %0d items, %0d errors", name, count, errors - e0);
    endtask

    // accepted input feeds the model
    always @(posedge clk) begin
        if (arst_n && in_valid && in_ready) begin
            exp_q.push_back(model_exec(instr, val_a, val_b, model_flags));
            model_flags = exp_q[$][67:64];
        end
    end

    always @(posedge clk) begin
        logic [69:0] exp;
        if (arst_n) begin
            if (stalled) begin
                check_val("held out_valid", {63'd0, out_valid}, 64'd1);
                check_val("held res", res, held[63:0]);
                check_val("held flags", {58'd0, branch_taken, illegal, nzcv}, {58'd0, held[69:64]});
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output transfer arrived with no instruction outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    check_val("res", res, exp[63:0]);
                    check_val("nzcv", {60'd0, nzcv}, {60'd0, exp[67:64]});
                    check_val("illegal", {63'd0, illegal}, {63'd0, exp[68]});
                    check_val("branch_taken", {63'd0, branch_taken}, {63'd0, exp[69]});
                end
            end
            stalled = out_valid && !out_ready;
            held    = {branch_taken, illegal, nzcv, res};
        end
    end

    always @(posedge clk) begin
        out_ready <= (($random(seed) & 3) != 0);
    end

    initial begin
        int cnt;
        seed        = 32'h5e525277;
        in_valid    = 1'b0;
        instr       = '0;
        val_a       = '0;
        val_b       = '0;
        out_ready   = 1'b0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        timed_out   = 1'b0;
        model_flags = 4'b0000;
        stalled     = 1'b0;
        op_fix  = '{11'h7c2, 11'h546, 11'h7c0, 11'h548, 11'h794, 11'h080, 11'h480, 11'h4d4,
                    11'h6d4, 11'h488, 11'h558, 11'h688, 11'h758, 11'h551, 11'h550, 11'h650,
                    11'h490, 11'h750, 11'h698, 11'h49c, 11'h49a, 11'h0a0, 11'h6b0, 11'h2a0,
                    11'h4a0, 11'h6b1, 11'h5a8, 11'h5a0, 11'h6b2, 11'h6a8, 11'h6a2};
        op_wild = '{11'h000, 11'h001, 11'h000, 11'h001, 11'h003, 11'h307, 11'h307, 11'h000,
                    11'h000, 11'h001, 11'h000, 11'h001, 11'h000, 11'h000, 11'h000, 11'h000,
                    11'h001, 11'h000, 11'h003, 11'h003, 11'h001, 11'h01f, 11'h000, 11'h007,
                    11'h01f, 11'h000, 11'h007, 11'h007, 11'h000, 11'h000, 11'h000};
        cnt = 0;
        while (!arst_n && !timed_out) begin
            @(posedge clk);
            cnt++;
            if (cnt > 100) begin
                $display("timeout: reset was never released");
                timed_out = 1'b1;
            end
        end
        @(posedge clk);
        check_val("out_valid after reset", {63'd0, out_valid}, 64'd0);
        check_val("in_ready after reset", {63'd0, in_ready}, 64'd1);
        if (!timed_out) run_test("reset", 0, 4);
        if (!timed_out) run_test("arith_logic", 1, 200);
        if (!timed_out) run_test("select", 2, 300);
        if (!timed_out) run_test("movk_bitfield", 3, 200);
        if (!timed_out) run_test("branch_illegal", 4, 200);
        if (!timed_out) run_test("stream", 5, 400);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
